// File: mem_unit.f
mem_cfg_pkg.sv
mem_bus_pkg.sv
smem_switch.sv
shared_mem.sv
mem_arb.sv
mem_perf.sv
mem_unit.sv
tb_mem_model.sv
tb_mem_unit.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_unit \
    -f mem_unit.f -o sim_mem_unit > build.log 2>&1 \
    && ./obj_dir/sim_mem_unit > sim.log 2>&1 \
    || echo "CHECKS FAILED" >> sim.log

cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1

// File: tb_mem_unit.sv
module tb_mem_unit
    import mem_cfg_pkg::*, mem_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int N_REQ      = 300;

    logic      clk;
    logic      reset;
    core_req_t fetch_req;
    logic      fetch_req_valid;
    logic      fetch_req_ready;
    core_rsp_t fetch_rsp;
    logic      fetch_rsp_valid;
    logic      fetch_rsp_ready;
    core_req_t data_req;
    logic      data_req_valid;
    logic      data_req_ready;
    core_rsp_t data_rsp;
    logic      data_rsp_valid;
    logic      data_rsp_ready;
    mem_req_t  mem_req;
    logic      mem_req_valid;
    logic      mem_req_ready;
    mem_rsp_t  mem_rsp;
    logic      mem_rsp_valid;
    logic      mem_rsp_ready;
    perf_mem_t perf;

    int unsigned lcg_state = 51276;
    int          error_count = 0;
    int          cycle = 0;
    logic        rsp_taken = 1'b0;
    logic        lat_armed = 1'b0;
    logic [CORE_TAG_WIDTH-1:0] lat_tag;

    // Expected memory-port traffic per source, in issue order
    mem_req_t fetch_q[$];
    mem_req_t data_q[$];
    mem_rsp_t rsp_q[$];
    int       rsp_due_q[$];

    mem_unit mem_unit_i (.*);
    tb_mem_model model_i ();

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    task automatic check(input string name, input logic [127:0] expected,
            input logic [127:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            error_count++;
            $display("CHECKS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic mem_req_t to_mem(core_req_t r, mem_src_e src);
        mem_req_t m;
        m.op     = r.op;
        m.addr   = r.addr;
        m.byteen = r.byteen;
        m.data   = r.data;
        m.tag    = {src, r.tag};
        return m;
    endfunction

    function automatic logic busy();
        return fetch_q.size() > 0 || data_q.size() > 0 || rsp_q.size() > 0
            || mem_rsp_valid || model_i.pend_count > 0;
    endfunction

    task automatic drive_fetch();
        int unsigned r;
        for (int i = 0; i < N_REQ; i++) begin
            @(negedge clk);
            r = next_rand();
            while (model_i.is_pending(SRC_FETCH, i[5:0]) || r[1:0] == 2'd0) begin
                fetch_req_valid = 1'b0;
                @(negedge clk);
                r = next_rand();
            end
            fetch_req.op     = OP_READ;
            fetch_req.addr   = next_rand() & 32'h7FEF_FFFF;
            fetch_req.byteen = '1;
            fetch_req.data   = next_rand();
            fetch_req.tag    = i[5:0];
            fetch_req_valid  = 1'b1;
            @(posedge clk);
            while (!fetch_req_ready) @(posedge clk);
        end
        @(negedge clk);
        fetch_req_valid = 1'b0;
    endtask

    task automatic drive_data();
        int unsigned r;
        for (int i = 0; i < N_REQ; i++) begin
            @(negedge clk);
            r = next_rand();
            while (model_i.is_pending(SRC_DATA, i[5:0])
                    || (i >= SMEM_DEPTH && r[1:0] == 2'd0)) begin
                data_req_valid = 1'b0;
                @(negedge clk);
                r = next_rand();
            end
            data_req.tag    = i[5:0];
            data_req.data   = next_rand();
            data_req.byteen = r[7:4];
            data_req.op     = r[8] ? OP_WRITE : OP_READ;
            data_req.addr   = next_rand();
            if (i < SMEM_DEPTH) begin
                // Preload every shared-memory word
                data_req.op     = OP_WRITE;
                data_req.byteen = '1;
                data_req.addr[ADDR_WIDTH-1 -: 8] = SMEM_REGION;
                data_req.addr[BANK_ADDR_OFFSET +: WARP_BITS] = i[5:4];
                data_req.addr[WORD_SEL_BITS-1:0] = i[3:0];
            end else if (r[9]) begin
                data_req.addr[ADDR_WIDTH-1 -: 8] = SMEM_REGION;
            end else if (data_req.op == OP_WRITE) begin
                data_req.addr = (data_req.addr & 32'h7FFF_FFFF) | 32'h0010_0000;
            end else begin
                data_req.addr = data_req.addr & 32'h7FEF_FFFF;
            end
            data_req_valid = 1'b1;
            @(posedge clk);
            while (!data_req_ready) @(posedge clk);
        end
        @(negedge clk);
        data_req_valid = 1'b0;
    endtask

    task automatic port_step();
        mem_req_t exp_req;
        logic     is_smem;
        if (lat_armed) begin
            check("smem_latency_valid", 1'b1, data_rsp_valid);
            check("smem_latency_tag", lat_tag, data_rsp.tag);
            lat_armed = 1'b0;
        end
        if (fetch_req_valid && fetch_req_ready) begin
            model_i.expect_read(SRC_FETCH, fetch_req.tag, model_i.ext_read(fetch_req.addr));
            fetch_q.push_back(to_mem(fetch_req, SRC_FETCH));
        end
        if (data_req_valid && data_req_ready) begin
            is_smem = data_req.addr[ADDR_WIDTH-1 -: 8] == SMEM_REGION;
            if (is_smem && data_req.op == OP_WRITE) begin
                model_i.smem_write(data_req.addr, data_req.byteen, data_req.data);
            end else if (is_smem) begin
                model_i.expect_read(SRC_DATA, data_req.tag, model_i.smem_read(data_req.addr));
                lat_armed = 1'b1;
                lat_tag   = data_req.tag;
            end else begin
                if (data_req.op == OP_READ) begin
                    model_i.expect_read(SRC_DATA, data_req.tag,
                        model_i.ext_read(data_req.addr));
                end
                data_q.push_back(to_mem(data_req, SRC_DATA));
            end
        end
        if (mem_req_valid && mem_req_ready) begin
            check("region_route", 1'b0, mem_req.addr[ADDR_WIDTH-1 -: 8] == SMEM_REGION);
            if (mem_req.tag[MEM_TAG_WIDTH-1] == SRC_DATA) begin
                if (data_q.size() == 0) fail_run("Unexpected data request on the memory port");
                exp_req = data_q.pop_front();
            end else begin
                if (fetch_q.size() == 0) fail_run("Unexpected fetch request on the memory port");
                exp_req = fetch_q.pop_front();
            end
            check("mem_req_order", exp_req, mem_req);
            if (mem_req.op == OP_READ) begin
                rsp_q.push_back({model_i.ext_read(mem_req.addr), mem_req.tag});
                rsp_due_q.push_back(cycle + 1 + int'(next_rand() % 6));
            end else begin
                model_i.ext_write(mem_req.addr, mem_req.byteen, mem_req.data);
            end
        end
    endtask

    task automatic rsp_step();
        if (mem_rsp_valid && mem_rsp_ready) rsp_taken = 1'b1;
        if (fetch_rsp_valid && fetch_rsp_ready) begin
            check("fetch_rsp_pending", 1'b1, model_i.is_pending(SRC_FETCH, fetch_rsp.tag));
            check("fetch_rsp_data", model_i.expected_data(SRC_FETCH, fetch_rsp.tag),
                fetch_rsp.data);
            model_i.retire(SRC_FETCH, fetch_rsp.tag);
        end
        if (data_rsp_valid && data_rsp_ready) begin
            check("data_rsp_pending", 1'b1, model_i.is_pending(SRC_DATA, data_rsp.tag));
            check("data_rsp_data", model_i.expected_data(SRC_DATA, data_rsp.tag),
                data_rsp.data);
            model_i.retire(SRC_DATA, data_rsp.tag);
        end
        model_i.perf_step(mem_req_valid && mem_req_ready && mem_req.op == OP_READ,
            mem_req_valid && mem_req_ready && mem_req.op == OP_WRITE,
            mem_rsp_valid && mem_rsp_ready);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            cycle++;
            port_step();
            rsp_step();
        end
    end

    // External memory, answers reads in order
    initial begin
        int unsigned r;
        forever begin
            @(negedge clk);
            r = next_rand();
            mem_req_ready   = r[0] | r[1];
            fetch_rsp_ready = r[2] | r[3];
            data_rsp_ready  = r[4] | r[5];
            if (rsp_taken) begin
                mem_rsp_valid = 1'b0;
                rsp_taken     = 1'b0;
            end
            if (!mem_rsp_valid && rsp_q.size() > 0 && cycle >= rsp_due_q[0]) begin
                mem_rsp       = rsp_q.pop_front();
                void'(rsp_due_q.pop_front());
                mem_rsp_valid = 1'b1;
            end
        end
    end

    initial begin
        #(N_REQ * 2 * 40 * CLK_PERIOD);
        fail_run("Timeout: the run did not finish in time");
    end

    initial begin
        reset           = 1'b1;
        fetch_req       = '0;
        fetch_req_valid = 1'b0;
        fetch_rsp_ready = 1'b0;
        data_req        = '0;
        data_req_valid  = 1'b0;
        data_rsp_ready  = 1'b0;
        mem_req_ready   = 1'b0;
        mem_rsp         = '0;
        mem_rsp_valid   = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        fork
            drive_fetch();
            drive_data();
        join
        while (busy()) @(negedge clk);
        repeat (3) @(negedge clk);
        check("perf_mem_reads", model_i.exp_reads, perf.mem_reads);
        check("perf_mem_writes", model_i.exp_writes, perf.mem_writes);
        check("perf_mem_latency", model_i.exp_latency, perf.mem_latency);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "errors found");
        end
    end

endmodule

// File: tb_mem_model.sv
module tb_mem_model
    import mem_cfg_pkg::*, mem_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TAG_COUNT = 1 << CORE_TAG_WIDTH;

    logic [WORD_WIDTH-1:0] smem_exp [SMEM_DEPTH];
    logic [WORD_WIDTH-1:0] ext_mem [logic [ADDR_WIDTH-1:0]];
    logic                  pend [2][TAG_COUNT];
    logic [WORD_WIDTH-1:0] exp_data [2][TAG_COUNT];
    int                    pend_count = 0;

    perf_ctr_t exp_reads   = '0;
    perf_ctr_t exp_writes  = '0;
    perf_ctr_t exp_latency = '0;
    perf_ctr_t exp_pending = '0;

    initial begin
        for (int s = 0; s < 2; s++) begin
            for (int t = 0; t < TAG_COUNT; t++) begin
                pend[s][t] = 1'b0;
            end
        end
    end

    // Word select in the low bits, warp field above it
    function automatic int smem_index(logic [ADDR_WIDTH-1:0] addr);
        return int'({addr[BANK_ADDR_OFFSET +: WARP_BITS], addr[WORD_SEL_BITS-1:0]});
    endfunction

    function automatic logic [WORD_WIDTH-1:0] merge_bytes(logic [WORD_WIDTH-1:0] old_word,
            logic [WORD_WIDTH-1:0] new_word, logic [BYTEEN_WIDTH-1:0] byteen);
        logic [WORD_WIDTH-1:0] w;
        w = old_word;
        for (int b = 0; b < BYTEEN_WIDTH; b++) begin
            if (byteen[b]) w[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return w;
    endfunction

    // Untouched external words follow the whole address
    function automatic logic [WORD_WIDTH-1:0] fill(logic [ADDR_WIDTH-1:0] addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [WORD_WIDTH-1:0] ext_read(logic [ADDR_WIDTH-1:0] addr);
        return ext_mem.exists(addr) ? ext_mem[addr] : fill(addr);
    endfunction

    task automatic ext_write(logic [ADDR_WIDTH-1:0] addr, logic [BYTEEN_WIDTH-1:0] byteen,
            logic [WORD_WIDTH-1:0] data);
        ext_mem[addr] = merge_bytes(ext_read(addr), data, byteen);
    endtask

    task automatic smem_write(logic [ADDR_WIDTH-1:0] addr, logic [BYTEEN_WIDTH-1:0] byteen,
            logic [WORD_WIDTH-1:0] data);
        smem_exp[smem_index(addr)] = merge_bytes(smem_exp[smem_index(addr)], data, byteen);
    endtask

    function automatic logic [WORD_WIDTH-1:0] smem_read(logic [ADDR_WIDTH-1:0] addr);
        return smem_exp[smem_index(addr)];
    endfunction

    task automatic expect_read(mem_src_e src, logic [CORE_TAG_WIDTH-1:0] tag,
            logic [WORD_WIDTH-1:0] data);
        pend[int'(src)][tag]     = 1'b1;
        exp_data[int'(src)][tag] = data;
        pend_count++;
    endtask

    function automatic logic is_pending(mem_src_e src, logic [CORE_TAG_WIDTH-1:0] tag);
        return pend[int'(src)][tag];
    endfunction

    function automatic logic [WORD_WIDTH-1:0] expected_data(mem_src_e src,
            logic [CORE_TAG_WIDTH-1:0] tag);
        return exp_data[int'(src)][tag];
    endfunction

    task automatic retire(mem_src_e src, logic [CORE_TAG_WIDTH-1:0] tag);
        pend[int'(src)][tag] = 1'b0;
        pend_count--;
    endtask

    // One clock of the memory-port counters
    task automatic perf_step(logic rd_fire, logic wr_fire, logic rsp_fire);
        exp_latency = exp_latency + exp_pending;
        if (rd_fire) exp_reads = exp_reads + 1;
        if (wr_fire) exp_writes = exp_writes + 1;
        if (rd_fire && !rsp_fire) exp_pending = exp_pending + 1;
        else if (rsp_fire && !rd_fire) exp_pending = exp_pending - 1;
    endtask

endmodule

// File: mem_unit.sv
module mem_unit
    import mem_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  core_req_t fetch_req,
    input  logic      fetch_req_valid,
    output logic      fetch_req_ready,
    output core_rsp_t fetch_rsp,
    output logic      fetch_rsp_valid,
    input  logic      fetch_rsp_ready,

    input  core_req_t data_req,
    input  logic      data_req_valid,
    output logic      data_req_ready,
    output core_rsp_t data_rsp,
    output logic      data_rsp_valid,
    input  logic      data_rsp_ready,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    input  mem_rsp_t  mem_rsp,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready,

    output perf_mem_t perf
);

    core_req_t smem_req;
    logic      smem_req_valid;
    logic      smem_req_ready;
    core_rsp_t smem_rsp;
    logic      smem_rsp_valid;
    logic      smem_rsp_ready;

    core_req_t ext_req;
    logic      ext_req_valid;
    logic      ext_req_ready;
    core_rsp_t ext_rsp;
    logic      ext_rsp_valid;
    logic      ext_rsp_ready;

    logic      mem_req_fire;
    logic      mem_rsp_fire;

    smem_switch smem_switch_i (
        .clk            (clk),
        .reset          (reset),
        .in_req         (data_req),
        .in_req_valid   (data_req_valid),
        .in_req_ready   (data_req_ready),
        .in_rsp         (data_rsp),
        .in_rsp_valid   (data_rsp_valid),
        .in_rsp_ready   (data_rsp_ready),
        .smem_req       (smem_req),
        .smem_req_valid (smem_req_valid),
        .smem_req_ready (smem_req_ready),
        .smem_rsp       (smem_rsp),
        .smem_rsp_valid (smem_rsp_valid),
        .smem_rsp_ready (smem_rsp_ready),
        .ext_req        (ext_req),
        .ext_req_valid  (ext_req_valid),
        .ext_req_ready  (ext_req_ready),
        .ext_rsp        (ext_rsp),
        .ext_rsp_valid  (ext_rsp_valid),
        .ext_rsp_ready  (ext_rsp_ready)
    );

    shared_mem shared_mem_i (
        .clk       (clk),
        .reset     (reset),
        .req       (smem_req),
        .req_valid (smem_req_valid),
        .req_ready (smem_req_ready),
        .rsp       (smem_rsp),
        .rsp_valid (smem_rsp_valid),
        .rsp_ready (smem_rsp_ready)
    );

    mem_arb mem_arb_i (
        .clk             (clk),
        .reset           (reset),
        .fetch_req       (fetch_req),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_req        (ext_req),
        .data_req_valid  (ext_req_valid),
        .data_req_ready  (ext_req_ready),
        .data_rsp        (ext_rsp),
        .data_rsp_valid  (ext_rsp_valid),
        .data_rsp_ready  (ext_rsp_ready),
        .mem_req         (mem_req),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp         (mem_rsp),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_ready   (mem_rsp_ready)
    );

    // Handshakes seen at the memory port
    assign mem_req_fire = mem_req_valid && mem_req_ready;
    assign mem_rsp_fire = mem_rsp_valid && mem_rsp_ready;

    mem_perf mem_perf_i (
        .clk          (clk),
        .reset        (reset),
        .mem_req_fire (mem_req_fire),
        .mem_req_op   (mem_req.op),
        .mem_rsp_fire (mem_rsp_fire),
        .perf         (perf)
    );

endmodule

// File: mem_perf.sv
module mem_perf
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_req_fire,
    input  req_op_e   mem_req_op,
    input  logic      mem_rsp_fire,
    output perf_mem_t perf
);

    perf_ctr_t pending_reads;
    logic      rd_fire;
    logic      wr_fire;

    assign rd_fire = mem_req_fire && (mem_req_op == OP_READ);
    assign wr_fire = mem_req_fire && (mem_req_op == OP_WRITE);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads <= '0;
        end else if (rd_fire && !mem_rsp_fire) begin
            pending_reads <= pending_reads + 1'b1;
        end else if (mem_rsp_fire && !rd_fire) begin
            pending_reads <= pending_reads - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            perf <= '0;
        end else begin
            if (rd_fire) begin
                perf.mem_reads <= perf.mem_reads + 1'b1;
            end
            if (wr_fire) begin
                perf.mem_writes <= perf.mem_writes + 1'b1;
            end
            // Every outstanding read adds one cycle
            perf.mem_latency <= perf.mem_latency + pending_reads;
        end
    end

endmodule

// File: mem_arb.sv
module mem_arb
    import mem_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  core_req_t fetch_req,
    input  logic      fetch_req_valid,
    output logic      fetch_req_ready,

    output core_rsp_t fetch_rsp,
    output logic      fetch_rsp_valid,
    input  logic      fetch_rsp_ready,

    input  core_req_t data_req,
    input  logic      data_req_valid,
    output logic      data_req_ready,

    output core_rsp_t data_rsp,
    output logic      data_rsp_valid,
    input  logic      data_rsp_ready,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,

    input  mem_rsp_t  mem_rsp,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready
);

    mem_src_e  prio;
    mem_src_e  grant;
    mem_src_e  lock_src;
    logic      lock_valid;
    mem_src_e  rsp_src;
    core_req_t sel_req;

    // Hold the grant while the memory port stalls
    always_comb begin
        if (lock_valid) begin
            grant = lock_src;
        end else if (fetch_req_valid && data_req_valid) begin
            grant = prio;
        end else if (data_req_valid) begin
            grant = SRC_DATA;
        end else begin
            grant = SRC_FETCH;
        end
    end

    assign sel_req = (grant == SRC_DATA) ? data_req : fetch_req;

    always_comb begin
        mem_req.op     = sel_req.op;
        mem_req.addr   = sel_req.addr;
        mem_req.byteen = sel_req.byteen;
        mem_req.data   = sel_req.data;
        mem_req.tag    = {grant, sel_req.tag};
    end

    assign mem_req_valid   = fetch_req_valid || data_req_valid;
    assign fetch_req_ready = mem_req_ready && (grant == SRC_FETCH);
    assign data_req_ready  = mem_req_ready && (grant == SRC_DATA);

    always_ff @(posedge clk) begin
        if (reset) begin
            prio       <= SRC_FETCH;
            lock_valid <= 1'b0;
            lock_src   <= SRC_FETCH;
        end else begin
            lock_valid <= mem_req_valid && !mem_req_ready;
            lock_src   <= grant;
            if (mem_req_valid && mem_req_ready) begin
                prio <= (grant == SRC_FETCH) ? SRC_DATA : SRC_FETCH;
            end
        end
    end

    // Response routed by the source bit
    assign rsp_src = mem_src_e'(mem_rsp.tag[MEM_TAG_WIDTH-1]);

    assign fetch_rsp.data  = mem_rsp.data;
    assign fetch_rsp.tag   = mem_rsp.tag[CORE_TAG_WIDTH-1:0];
    assign data_rsp.data   = mem_rsp.data;
    assign data_rsp.tag    = mem_rsp.tag[CORE_TAG_WIDTH-1:0];
    assign fetch_rsp_valid = mem_rsp_valid && (rsp_src == SRC_FETCH);
    assign data_rsp_valid  = mem_rsp_valid && (rsp_src == SRC_DATA);
    assign mem_rsp_ready   = (rsp_src == SRC_FETCH) ? fetch_rsp_ready : data_rsp_ready;

    a_grant_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req)
    ) else $error("mem_arb: granted request changed before accept");

endmodule

// File: shared_mem.sv
module shared_mem
    import mem_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  core_req_t req,
    input  logic      req_valid,
    output logic      req_ready,

    output core_rsp_t rsp,
    output logic      rsp_valid,
    input  logic      rsp_ready
);

    logic [WORD_WIDTH-1:0]      mem_array [SMEM_DEPTH];
    logic [SMEM_ADDR_WIDTH-1:0] smem_addr;
    logic                       rsp_stall;
    logic                       req_fire;
    logic                       rd_fire;
    logic                       wr_fire;

    // Warp field above the word select
    assign smem_addr = {req.addr[BANK_ADDR_OFFSET +: WARP_BITS],
                        req.addr[0 +: WORD_SEL_BITS]};

    assign rsp_stall = rsp_valid && !rsp_ready;
    assign req_ready = !rsp_stall;

    assign req_fire = req_valid && req_ready;
    assign rd_fire  = req_fire && (req.op == OP_READ);
    assign wr_fire  = req_fire && (req.op == OP_WRITE);

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < BYTEEN_WIDTH; b++) begin
                if (req.byteen[b]) begin
                    mem_array[smem_addr][b*BYTE_WIDTH +: BYTE_WIDTH] <=
                        req.data[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // Output register loaded on read accept
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp.data <= mem_array[smem_addr];
            rsp.tag  <= req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    a_no_read_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        rsp_stall |-> !rd_fire
    ) else $error("shared_mem: read accepted while response stalled");

endmodule

// File: smem_switch.sv
module smem_switch
    import mem_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  core_req_t in_req,
    input  logic      in_req_valid,
    output logic      in_req_ready,

    output core_rsp_t in_rsp,
    output logic      in_rsp_valid,
    input  logic      in_rsp_ready,

    output core_req_t smem_req,
    output logic      smem_req_valid,
    input  logic      smem_req_ready,

    input  core_rsp_t smem_rsp,
    input  logic      smem_rsp_valid,
    output logic      smem_rsp_ready,

    output core_req_t ext_req,
    output logic      ext_req_valid,
    input  logic      ext_req_ready,

    input  core_rsp_t ext_rsp,
    input  logic      ext_rsp_valid,
    output logic      ext_rsp_ready
);

    logic is_smem;

    assign is_smem = (in_req.addr[ADDR_WIDTH-1 -: REGION_BITS] == SMEM_REGION);

    // Same payload on both paths, only one valid
    assign smem_req       = in_req;
    assign ext_req        = in_req;
    assign smem_req_valid = in_req_valid && is_smem;
    assign ext_req_valid  = in_req_valid && !is_smem;
    assign in_req_ready   = is_smem ? smem_req_ready : ext_req_ready;

    // Shared memory wins, external response waits
    assign in_rsp_valid   = smem_rsp_valid || ext_rsp_valid;
    assign in_rsp         = smem_rsp_valid ? smem_rsp : ext_rsp;
    assign smem_rsp_ready = in_rsp_ready;
    assign ext_rsp_ready  = in_rsp_ready && !smem_rsp_valid;

    a_one_path: assert property (
        @(posedge clk) disable iff (reset)
        !(smem_req_valid && ext_req_valid)
    ) else $error("smem_switch: request valid toward both paths");

    // A stalled request keeps its path until it is taken
    a_path_held: assert property (
        @(posedge clk) disable iff (reset)
        smem_req_valid && !smem_req_ready |=> smem_req_valid
    ) else $error("smem_switch: shared-memory request left its path");

endmodule

// File: mem_bus_pkg.sv
package mem_bus_pkg;
    import mem_cfg_pkg::*;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    // Stored as the top bit of the memory tag
    typedef enum logic {
        SRC_FETCH = 1'b0,
        SRC_DATA  = 1'b1
    } mem_src_e;

    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;

    typedef struct packed {
        req_op_e                   op;
        logic [ADDR_WIDTH-1:0]     addr;
        logic [BYTEEN_WIDTH-1:0]   byteen;
        logic [WORD_WIDTH-1:0]     data;
        logic [CORE_TAG_WIDTH-1:0] tag;
    } core_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0]     data;
        logic [CORE_TAG_WIDTH-1:0] tag;
    } core_rsp_t;

    typedef struct packed {
        req_op_e                  op;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [BYTEEN_WIDTH-1:0]  byteen;
        logic [WORD_WIDTH-1:0]    data;
        logic [MEM_TAG_WIDTH-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0]    data;
        logic [MEM_TAG_WIDTH-1:0] tag;
    } mem_rsp_t;

    typedef struct packed {
        perf_ctr_t mem_reads;
        perf_ctr_t mem_writes;
        perf_ctr_t mem_latency;
    } perf_mem_t;

endpackage

// File: mem_cfg_pkg.sv
package mem_cfg_pkg;

    // Word-addressed request bus
    localparam int ADDR_WIDTH   = 32;
    localparam int WORD_WIDTH   = 32;
    localparam int BYTEEN_WIDTH = 4;
    localparam int BYTE_WIDTH   = WORD_WIDTH / BYTEEN_WIDTH;

    // Core tag, widened by one source bit on the memory port
    localparam int CORE_TAG_WIDTH = 6;
    localparam int MEM_TAG_WIDTH  = CORE_TAG_WIDTH + 1;

    // Address map
    // Top address byte selects the shared-memory region
    localparam int              REGION_BITS = 8;
    localparam [REGION_BITS-1:0] SMEM_REGION = 8'hFF;

    // Shared memory remap fields
    localparam int WORD_SEL_BITS    = 4;
    localparam int WARP_BITS        = 2;
    localparam int BANK_ADDR_OFFSET = 6;
    localparam int SMEM_ADDR_WIDTH  = WORD_SEL_BITS + WARP_BITS;
    localparam int SMEM_DEPTH       = 1 << SMEM_ADDR_WIDTH;

    // Performance counters
    localparam int PERF_CTR_BITS = 32;

endpackage
